/* dft_src_cfg.svh */
`ifndef DFT_SRC_CFG_SVH
`define DFT_SRC_CFG_SVH

// Points are interleaved over this many banks so that index k lives in bank k mod 7
`define DFT_SRC_BANKS 7

// Width of a linear point index and of dftpts
`define DFT_SRC_IDX_W 12

// Word address inside one bank
`define DFT_SRC_BADDR_W 9

// One real or imaginary component of a sample
`define DFT_SRC_SAMPLE_W 16

// Seven banks of 512 words
`define DFT_SRC_MAX_PTS 3584

`endif

/* dft_src_pkg.sv */
package dft_src_pkg;

	`include "dft_src_cfg.svh"

	typedef logic [`DFT_SRC_IDX_W-1:0] point_idx_t;
	typedef logic [2:0] bank_sel_t;
	typedef logic [`DFT_SRC_BADDR_W-1:0] bank_addr_t;

	typedef struct packed
	{
		logic [`DFT_SRC_SAMPLE_W-1:0] re;
		logic [`DFT_SRC_SAMPLE_W-1:0] im;
	} sample_t;

	// Location of one point in the interleaved memory
	typedef struct packed
	{
		bank_addr_t addr;
		bank_sel_t  bank;
	} bank_loc_t;

	// Restoring division by the constant seven with one dividend bit per step
	function automatic bank_loc_t dft_src_split(input point_idx_t idx);
		logic [3:0] rem;
		point_idx_t quo;
		bank_loc_t  loc;
		rem = '0;
		quo = '0;
		for (int i = `DFT_SRC_IDX_W - 1; i >= 0; i--)
		begin
			rem = {rem[2:0], idx[i]};
			if (rem >= 4'd7)
			begin
				rem = rem - 4'd7;
				quo[i] = 1'b1;
			end
		end
		// The quotient stays below 512 for any supported transform size
		loc.addr = quo[`DFT_SRC_BADDR_W-1:0];
		loc.bank = rem[2:0];
		return loc;
	endfunction

endpackage

/* dft_src_decode.sv */
`timescale 1ns/100ps

module dft_src_decode
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    req,
	input  dft_src_pkg::point_idx_t dftpts,
	output logic                    rd_en,
	output dft_src_pkg::bank_sel_t  rd_bank,
	output dft_src_pkg::bank_addr_t rd_addr,
	output logic                    rd_first,
	output logic                    rd_last
);

	import dft_src_pkg::*;

	point_idx_t cnt;
	point_idx_t last_idx;
	bank_loc_t  cnt_loc;
	logic       active;
	logic       done;
	logic       at_last;

	assign last_idx = dftpts - point_idx_t'(1);
	assign at_last  = (cnt == last_idx);

	// Bank and bank address of the point about to be issued
	always_comb
	begin
		cnt_loc = dft_src_split(cnt);
	end

	// Frame sequencing
	// done keeps a finished frame from restarting until req has dropped
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			active <= 1'b0;
			done   <= 1'b0;
			cnt    <= '0;
		end
		else
		begin
			if (active)
			begin
				if (at_last)
				begin
					active <= 1'b0;
					cnt    <= '0;
				end
				else
				begin
					cnt <= cnt + point_idx_t'(1);
				end
			end
			else if (req && !done)
			begin
				active <= 1'b1;
				cnt    <= '0;
			end

			if (active && at_last)
				done <= 1'b1;
			else if (!req)
				done <= 1'b0;
		end
	end

	// Registered read request toward the banks
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_en    <= 1'b0;
			rd_first <= 1'b0;
			rd_last  <= 1'b0;
		end
		else
		begin
			rd_en    <= active;
			rd_first <= active && (cnt == '0);
			rd_last  <= active && at_last;
		end
	end

	always_ff @(posedge clk)
	begin
		rd_bank <= cnt_loc.bank;
		rd_addr <= cnt_loc.addr;
	end

endmodule

/* dft_src_execute.sv */
`timescale 1ns/100ps

`include "dft_src_cfg.svh"

module dft_src_execute
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    req,
	input  logic                    wr_en,
	input  dft_src_pkg::point_idx_t wr_idx,
	input  dft_src_pkg::sample_t    wr_data,
	input  logic                    rd_en,
	input  dft_src_pkg::bank_sel_t  rd_bank,
	input  dft_src_pkg::bank_addr_t rd_addr,
	input  logic                    rd_first,
	input  logic                    rd_last,
	output logic                    q_valid,
	output logic                    q_first,
	output logic                    q_last,
	output dft_src_pkg::sample_t    q_data
);

	import dft_src_pkg::*;

	localparam int DEPTH = `DFT_SRC_MAX_PTS / `DFT_SRC_BANKS;

	bank_loc_t                 wr_loc;
	logic                      wr_ok;
	logic [`DFT_SRC_BANKS-1:0] rd_oh;
	sample_t                   bank_q [`DFT_SRC_BANKS];
	bank_sel_t                 bank_r;
	logic                      rd_en_r;
	logic                      rd_first_r;
	logic                      rd_last_r;

	// The banks are frozen while a frame is being read out
	assign wr_ok = wr_en && !req;

	always_comb
	begin
		wr_loc = dft_src_split(wr_idx);
	end

	// Only the addressed bank is enabled for a read
	always_comb
	begin
		rd_oh = '0;
		if (rd_en)
			rd_oh[rd_bank] = 1'b1;
	end

	for (genvar b = 0; b < `DFT_SRC_BANKS; b++)
	begin : g_bank
		sample_t mem [DEPTH];

		always_ff @(posedge clk)
		begin
			if (wr_ok && (wr_loc.bank == bank_sel_t'(b)))
				mem[wr_loc.addr] <= wr_data;
			if (rd_oh[b])
				bank_q[b] <= mem[rd_addr];
		end
	end

	// Stage one travels beside the bank read
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_en_r    <= 1'b0;
			rd_first_r <= 1'b0;
			rd_last_r  <= 1'b0;
		end
		else
		begin
			rd_en_r    <= rd_en;
			rd_first_r <= rd_first;
			rd_last_r  <= rd_last;
		end
	end

	always_ff @(posedge clk)
	begin
		bank_r <= rd_bank;
	end

	// Stage two picks the word of the bank that was read
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			q_valid <= 1'b0;
			q_first <= 1'b0;
			q_last  <= 1'b0;
		end
		else
		begin
			q_valid <= rd_en_r;
			q_first <= rd_first_r;
			q_last  <= rd_last_r;
		end
	end

	always_ff @(posedge clk)
	begin
		q_data <= bank_q[bank_r];
	end

endmodule

/* dft_src_result.sv */
`timescale 1ns/100ps

module dft_src_result
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 req,
	input  logic                 q_valid,
	input  logic                 q_first,
	input  logic                 q_last,
	input  dft_src_pkg::sample_t q_data,
	output logic                 out_valid,
	output logic                 out_sop,
	output logic                 out_eop,
	output dft_src_pkg::sample_t out_data,
	output logic                 ack
);

	logic frame_end;

	// The eop beat is on the output in this cycle
	assign frame_end = out_valid && out_eop;

	// The sop and eop marks only count on a valid beat
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			out_sop   <= 1'b0;
			out_eop   <= 1'b0;
		end
		else
		begin
			out_valid <= q_valid;
			out_sop   <= q_valid && q_first;
			out_eop   <= q_valid && q_last;
		end
	end

	always_ff @(posedge clk)
	begin
		out_data <= q_data;
	end

	// Four-phase acknowledge
	// ack goes high after the eop beat and returns low once req is seen low
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ack <= 1'b0;
		end
		else
		begin
			if (frame_end)
				ack <= 1'b1;
			else if (!req)
				ack <= 1'b0;
		end
	end

endmodule

/* dft_src_top.sv */
`timescale 1ns/100ps

module dft_src_top
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    wr_en,
	input  dft_src_pkg::point_idx_t wr_idx,
	input  dft_src_pkg::sample_t    wr_data,
	input  logic                    req,
	input  dft_src_pkg::point_idx_t dftpts,
	output logic                    ack,
	output logic                    out_valid,
	output logic                    out_sop,
	output logic                    out_eop,
	output dft_src_pkg::sample_t    out_data
);

	import dft_src_pkg::*;

	logic       rd_en;
	bank_sel_t  rd_bank;
	bank_addr_t rd_addr;
	logic       rd_first;
	logic       rd_last;
	logic       q_valid;
	logic       q_first;
	logic       q_last;
	sample_t    q_data;

	// Point counter and bank split
	dft_src_decode u_decode
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.req      (req),
		.dftpts   (dftpts),
		.rd_en    (rd_en),
		.rd_bank  (rd_bank),
		.rd_addr  (rd_addr),
		.rd_first (rd_first),
		.rd_last  (rd_last)
	);

	// Interleaved banks with their write port
	dft_src_execute u_execute
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.req      (req),
		.wr_en    (wr_en),
		.wr_idx   (wr_idx),
		.wr_data  (wr_data),
		.rd_en    (rd_en),
		.rd_bank  (rd_bank),
		.rd_addr  (rd_addr),
		.rd_first (rd_first),
		.rd_last  (rd_last),
		.q_valid  (q_valid),
		.q_first  (q_first),
		.q_last   (q_last),
		.q_data   (q_data)
	);

	dft_src_result u_result
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.q_valid   (q_valid),
		.q_first   (q_first),
		.q_last    (q_last),
		.q_data    (q_data),
		.out_valid (out_valid),
		.out_sop   (out_sop),
		.out_eop   (out_eop),
		.out_data  (out_data),
		.ack       (ack)
	);

endmodule

/* tb_clkgen.sv */
`timescale 1ns/100ps

module tb_clkgen
(
	output logic clk,
	output logic rst_n
);

	// 40 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	// Reset spans ten rising edges and is released just after the last one
	initial
	begin
		rst_n = 1'b0;
		repeat (10)
			@(posedge clk);
		#2;
		rst_n = 1'b1;
	end

endmodule

/* tb_dft_src_asserts.sv */
`timescale 1ns/100ps

module tb_dft_src_asserts
(
	input logic clk,
	input logic rst_n,
	input logic req,
	input logic ack,
	input logic out_valid,
	input logic out_sop,
	input logic out_eop
);

	int fail_count = 0;

	a_sop_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
		out_sop |-> out_valid)
	else
	begin
		$error("sop raised outside a valid beat");
		fail_count++;
	end

	a_eop_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
		out_eop |-> out_valid)
	else
	begin
		$error("eop raised outside a valid beat");
		fail_count++;
	end

	// ack follows the eop beat by exactly one cycle
	a_ack_after_eop: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && out_eop) |=> ack)
	else
	begin
		$error("ack did not rise the cycle after eop");
		fail_count++;
	end

	a_ack_rise_cause: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ack) |-> $past(out_valid && out_eop))
	else
	begin
		$error("ack rose without an eop beat in the cycle before");
		fail_count++;
	end

	a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
		(ack && !req) |=> !ack)
	else
	begin
		$error("ack still high one cycle after req was low");
		fail_count++;
	end

	a_no_beat_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!req |-> !out_valid)
	else
	begin
		$error("valid beat while req is low");
		fail_count++;
	end

	// Checks the values that reset leaves on the outputs
	a_reset_values: assert property (@(posedge clk)
		!rst_n |=> (!out_valid && !out_sop && !out_eop && !ack))
	else
	begin
		$error("outputs not low after reset");
		fail_count++;
	end

endmodule

/* tb_dft_src.sv */
`timescale 1ns/100ps

module tb_dft_src;

	import dft_src_pkg::*;

	logic       clk;
	logic       rst_n;
	logic       wr_en;
	point_idx_t wr_idx;
	sample_t    wr_data;
	logic       req;
	point_idx_t dftpts;
	logic       ack;
	logic       out_valid;
	logic       out_sop;
	logic       out_eop;
	sample_t    out_data;

	// Reference copy of what the banks should hold
	sample_t model [64];
	int      exp_pts = 0;
	int      beat = 0;
	logic    in_frame = 1'b0;

	tb_clkgen u_clkgen
	(
		.clk   (clk),
		.rst_n (rst_n)
	);

	dft_src_top dut
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_en     (wr_en),
		.wr_idx    (wr_idx),
		.wr_data   (wr_data),
		.req       (req),
		.dftpts    (dftpts),
		.ack       (ack),
		.out_valid (out_valid),
		.out_sop   (out_sop),
		.out_eop   (out_eop),
		.out_data  (out_data)
	);

	bind dft_src_top tb_dft_src_asserts u_asserts
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.ack       (ack),
		.out_valid (out_valid),
		.out_sop   (out_sop),
		.out_eop   (out_eop)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic stop_with_failure();
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
		stop_with_failure();
	endtask

	task automatic report_problem(input string what);
		$display("t=%0t %s", $time, what);
		stop_with_failure();
	endtask

	// Inputs change 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic wait_for_reset();
		int n;
		n = 0;
		while (rst_n !== 1'b1)
		begin
			if (n >= 20)
				report_problem("reset was never released");
			next_cycle();
			n++;
		end
	endtask

	task automatic wait_for_ack(input logic level, input int limit);
		int n;
		n = 0;
		while (ack !== level)
		begin
			if (n >= limit)
				report_problem($sformatf("timed out waiting for ack to become %0b", level));
			next_cycle();
			n++;
		end
	endtask

	task automatic write_sample(input int idx, input sample_t data);
		wr_en   = 1'b1;
		wr_idx  = point_idx_t'(idx);
		wr_data = data;
		next_cycle();
		wr_en   = 1'b0;
	endtask

	// One full four-phase transfer with optional writes that must be ignored
	task automatic run_frame(input int npts, input bit write_while_busy);
		int i;
		dftpts  = point_idx_t'(npts);
		exp_pts = npts;
		beat    = 0;
		req     = 1'b1;
		wait_for_ack(1'b1, npts + 20);
		assert (beat == npts) else report_mismatch("beat count", npts, beat);
		for (i = 0; i < 4; i++)
		begin
			if (write_while_busy)
			begin
				wr_en   = 1'b1;
				wr_idx  = point_idx_t'(i);
				wr_data = ~model[i];
			end
			next_cycle();
			assert (ack) else report_mismatch("ack", 1, ack);
		end
		wr_en = 1'b0;
		req   = 1'b0;
		wait_for_ack(1'b0, npts + 20);
	endtask

	// Beat checker on the falling edge where the outputs are settled
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			if (out_valid)
			begin
				assert (beat < exp_pts) else report_problem("valid beat past the end of the frame");
				assert (out_data == model[beat])
					else report_mismatch("out_data", model[beat], out_data);
				assert (out_sop == (beat == 0))
					else report_mismatch("out_sop", beat == 0, out_sop);
				assert (out_eop == (beat == exp_pts - 1))
					else report_mismatch("out_eop", beat == exp_pts - 1, out_eop);
				beat++;
				in_frame = !out_eop;
			end
			else
			begin
				assert (!in_frame) else report_problem("gap between beats inside a frame");
			end
			if (dut.u_asserts.fail_count != 0)
				report_problem("a protocol assertion on the DUT failed");
		end
	end

	initial
	begin
		logic [31:0] seed;
		wr_en   = 1'b0;
		wr_idx  = '0;
		wr_data = '0;
		req     = 1'b0;
		dftpts  = '0;
		wait_for_reset();

		// Idle outputs before any request
		repeat (5)
		begin
			next_cycle();
			assert (!out_valid && !out_sop && !out_eop && !ack)
				else report_problem("outputs active before the first request");
		end

		seed = 32'h4e55;
		for (int i = 0; i < 60; i++)
		begin
			seed = xorshift32(seed);
			model[i] = seed;
			write_sample(i, model[i]);
		end

		// Sixty points cover all seven banks and the ignored writes hit points 0 to 3
		run_frame(60, 1'b1);
		run_frame(13, 1'b0);
		run_frame(1, 1'b0);

		repeat (3)
			next_cycle();
		if (dut.u_asserts.fail_count == 0)
		begin
			$display("NO ERRORS");
			$finish;
		end
		else
		begin
			stop_with_failure();
		end
	end

endmodule

/* tb.f */
+incdir+.
dft_src_pkg.sv
dft_src_decode.sv
dft_src_execute.sv
dft_src_result.sv
dft_src_top.sv
tb_clkgen.sv
tb_dft_src_asserts.sv
tb_dft_src.sv
